// ==== rtl/la_capture_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_capture_fsm (
   input  wire                               observer_clk,
   input  wire                               reset,
   input  wire                               arm,
   input  wire                               trigger_edge,
   input  wire                               tick,
   input  wire                               stall,
   input  wire [la_pkg::count_width-1:0]     depth,
   output logic                              start,
   output logic                              sample_en,
   output logic                              armed,
   output logic                              capturing
);

   typedef enum logic [1:0] {
      st_idle,
      st_armed,
      st_capture
   } state_t;

   state_t state;

   logic arm_sync0;
   logic arm_sync1;
   logic arm_prev;
   logic arm_rise;

   logic [la_pkg::count_width-1:0] sample_count; // Accepted samples so far
   logic [la_pkg::count_width:0]   next_count;

   assign arm_rise  = arm_sync1 & ~arm_prev;
   assign armed     = (state == st_armed);
   assign capturing = (state == st_capture);

   // Samples lost to back-pressure are simply skipped
   assign sample_en  = capturing & tick & ~stall;
   assign next_count = {1'b0, sample_count} + 1'b1;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_sync0 <= 1'b0;
         arm_sync1 <= 1'b0;
         arm_prev  <= 1'b0;
      end
      else begin
         arm_sync0 <= arm;
         arm_sync1 <= arm_sync0;
         arm_prev  <= arm_sync1;
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state        <= st_idle;
         start        <= 1'b0;
         sample_count <= '0;
      end
      else begin
         // One-shot: only an armed, idle engine can start
         start <= trigger_edge & (state == st_armed);

         case (state)
            st_idle: begin
               if (arm_rise)
                  state <= st_armed;
            end

            st_armed: begin
               if (start) begin
                  state        <= st_capture; // Clears armed
                  sample_count <= '0;
               end
            end

            st_capture: begin
               if (sample_en) begin
                  sample_count <= next_count[la_pkg::count_width-1:0];
                  if (next_count >= {1'b0, depth})
                     state <= st_idle; // Depth reached
               end
            end

            default: state <= st_idle;
         endcase
      end
   end

   // Depth compare needs a steady config through the capture
   a_depth_stable: assert property (
      @(posedge observer_clk) disable iff (reset)
      capturing |=> $stable(depth));

   // Packer and timer rely on start landing outside a capture
   a_no_start_while_capturing: assert property (
      @(posedge observer_clk) disable iff (reset)
      start |-> !capturing ##1 (capturing && !armed));

endmodule

`default_nettype wire

// ==== rtl/la_channel_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_channel_select (
   input  wire                                observer_clk,
   input  wire                                reset,
   input  wire [2:0]                          capture_group,
   input  la_pkg::la_probes_t                 probes,
   output logic [la_pkg::num_channels-1:0]    channels
);

   // Registered so the packer sees a clean sample
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         channels <= '0;
      end
      else begin
         case (capture_group)
            la_pkg::group_glitch: channels <= probes.glitch;
            la_pkg::group_io:     channels <= probes.io;
            la_pkg::group_userio: channels <= probes.userio;
            la_pkg::group_debug:  channels <= probes.debug;
            la_pkg::group_trace:  channels <= probes.trace;
            default:              channels <= la_pkg::default_pattern; // Known pattern
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/la_pkg.sv ====
`default_nettype none

package la_pkg;

   // Sizes
   localparam int num_channels = 9;
   localparam int word_width   = 2 * num_channels; // Two samples per channel
   localparam int count_width  = 16;

   // Trigger source codes, anything above 5 picks debug bit 1
   localparam logic [2:0] trig_glitch_go      = 3'd0;
   localparam logic [2:0] trig_capture_active = 3'd1;
   localparam logic [2:0] trig_glitch_manual  = 3'd2;
   localparam logic [2:0] trig_hs1            = 3'd3;
   localparam logic [2:0] trig_glitch_trigger = 3'd4;
   localparam logic [2:0] trig_debug0         = 3'd5;

   // Probe bit positions of the trigger sources
   localparam int glitch_go_bit      = 4;
   localparam int capture_active_bit = 5;
   localparam int glitch_manual_bit  = 7;
   localparam int glitch_trigger_bit = 8;
   localparam int hs1_bit            = 4;

   // Channel group codes, 5 to 7 give the default pattern
   localparam logic [2:0] group_glitch = 3'd0;
   localparam logic [2:0] group_io     = 3'd1;
   localparam logic [2:0] group_userio = 3'd2;
   localparam logic [2:0] group_debug  = 3'd3;
   localparam logic [2:0] group_trace  = 3'd4;

   localparam logic [num_channels-1:0] default_pattern = 9'b1_0101_0101;

   typedef struct packed {
      logic [2:0]             trigger_source;
      logic [2:0]             capture_group;
      logic                   manual_capture;
      logic [count_width-1:0] depth;      // Samples per capture
      logic [count_width-1:0] downsample; // Idle cycles between samples
   } la_config_t;

   typedef struct packed {
      logic [num_channels-1:0] trace;
      logic [num_channels-1:0] debug;
      logic [num_channels-1:0] userio;
      logic [num_channels-1:0] io;
      logic [num_channels-1:0] glitch;
   } la_probes_t;

   // Channel k in bits 2k+1:2k, older sample in [1]
   typedef logic [num_channels-1:0][1:0] la_word_t;

endpackage

`default_nettype wire

// ==== rtl/la_sample_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_sample_packer (
   input  wire                             observer_clk,
   input  wire                             reset,
   input  wire                             start,
   input  wire                             sample_en,
   input  wire [la_pkg::num_channels-1:0]  channels,
   input  wire                             word_ready,
   output logic                            word_valid,
   output la_pkg::la_word_t                word_data,
   output logic                            stall
);

   la_pkg::la_word_t history;  // Two-sample history per channel
   la_pkg::la_word_t shifted;
   logic             phase;    // High on the second sample of a pair

   always_comb begin
      for (int k = 0; k < la_pkg::num_channels; k++) begin
         shifted[k] = {history[k][0], channels[k]}; // Older sample moves up
      end
   end

   assign stall = word_valid & ~word_ready;

   always_ff @(posedge observer_clk) begin
      if (sample_en) begin
         history <= shifted;
         if (phase)
            word_data <= shifted;
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         phase      <= 1'b0;
         word_valid <= 1'b0;
      end
      else begin
         if (start)
            phase <= 1'b0;
         else if (sample_en)
            phase <= ~phase;

         // New word may replace the one accepted this cycle
         if (sample_en && phase)
            word_valid <= 1'b1;
         else if (word_ready)
            word_valid <= 1'b0;
      end
   end

   a_hold_while_stalled: assert property (
      @(posedge observer_clk) disable iff (reset)
      (word_valid && !word_ready) |=> (word_valid && $stable(word_data)));

endmodule

`default_nettype wire

// ==== rtl/la_sample_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_sample_timer (
   input  wire                           observer_clk,
   input  wire                           reset,
   input  wire                           start,
   input  wire [la_pkg::count_width-1:0] downsample,
   output logic                          tick
);

   logic [la_pkg::count_width-1:0] count;
   logic                           count_max;

   assign count_max = (count == downsample);

   // Free running, realigned by every start
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         count <= '0;
         tick  <= 1'b0;
      end
      else if (start) begin
         count <= '0;
         tick  <= 1'b0;
      end
      else if (count_max) begin
         count <= '0;
         tick  <= 1'b1; // One cycle every downsample+1
      end
      else begin
         count <= count + 1'b1;
         tick  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/la_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_top (
   input  wire                                observer_clk,
   input  wire                                reset,
   input  la_pkg::la_config_t                 cfg,
   input  la_pkg::la_probes_t                 probes,
   input  wire                                arm,
   input  wire                                word_ready,
   output logic                               word_valid,
   output la_pkg::la_word_t                   word_data,
   output logic                               armed,
   output logic                               capturing
);

   logic                            trigger_edge;
   logic                            start;
   logic                            sample_en;
   logic                            tick;
   logic                            stall;
   logic [la_pkg::num_channels-1:0] channels;

   la_trigger_detect u_trigger_detect (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cfg          (cfg),
      .probes       (probes),
      .trigger_edge (trigger_edge)
   );

   la_capture_fsm u_capture_fsm (
      .observer_clk (observer_clk),
      .reset        (reset),
      .arm          (arm),
      .trigger_edge (trigger_edge),
      .tick         (tick),
      .stall        (stall),
      .depth        (cfg.depth),
      .start        (start),
      .sample_en    (sample_en),
      .armed        (armed),
      .capturing    (capturing)
   );

   la_sample_timer u_sample_timer (
      .observer_clk (observer_clk),
      .reset        (reset),
      .start        (start),
      .downsample   (cfg.downsample),
      .tick         (tick)
   );

   la_channel_select u_channel_select (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_group (cfg.capture_group),
      .probes        (probes),
      .channels      (channels)
   );

   la_sample_packer u_sample_packer (
      .observer_clk (observer_clk),
      .reset        (reset),
      .start        (start),
      .sample_en    (sample_en),
      .channels     (channels),
      .word_ready   (word_ready),
      .word_valid   (word_valid),
      .word_data    (word_data),
      .stall        (stall)
   );

endmodule

`default_nettype wire

// ==== rtl/la_trigger_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_trigger_detect (
   input  wire                 observer_clk,
   input  wire                 reset,
   input  la_pkg::la_config_t  cfg,
   input  la_pkg::la_probes_t  probes,
   output logic                trigger_edge
);

   logic source_sel;
   logic capture_go;
   logic go_sync0;  // First synchronizer stage
   logic go_sync1;
   logic go_prev;

   // Source mux
   always_comb begin
      case (cfg.trigger_source)
         la_pkg::trig_glitch_go:
            source_sel = probes.glitch[la_pkg::glitch_go_bit];
         la_pkg::trig_capture_active:
            source_sel = probes.glitch[la_pkg::capture_active_bit];
         la_pkg::trig_glitch_manual:
            source_sel = probes.glitch[la_pkg::glitch_manual_bit];
         la_pkg::trig_hs1:
            source_sel = probes.io[la_pkg::hs1_bit];
         la_pkg::trig_glitch_trigger:
            source_sel = probes.glitch[la_pkg::glitch_trigger_bit];
         la_pkg::trig_debug0:
            source_sel = probes.debug[0];
         default:
            source_sel = probes.debug[1];
      endcase
   end

   assign capture_go = source_sel | cfg.manual_capture; // Manual trigger overrides

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         go_sync0     <= 1'b0;
         go_sync1     <= 1'b0;
         go_prev      <= 1'b0;
         trigger_edge <= 1'b0;
      end
      else begin
         go_sync0     <= capture_go;
         go_sync1     <= go_sync0;
         go_prev      <= go_sync1;
         trigger_edge <= go_sync1 & ~go_prev; // Rising edge only
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/la_pkg.sv
rtl/la_trigger_detect.sv
rtl/la_capture_fsm.sv
rtl/la_sample_timer.sv
rtl/la_channel_select.sv
rtl/la_sample_packer.sv
rtl/la_top.sv
testbench/la_tb.sv

// ==== testbench/la_stimulus.txt ====
# src grp manual depth downsample pattern(hex) arm ready(0 always, 1 random) expected_words
# pattern is the nine channels of the selected group, other groups carry its inverse
0 0 0 16 0 0a5 1 0 8
1 1 0 12 1 13c 1 0 6
2 2 0 10 2 0f0 1 0 5
3 3 0 14 0 1e1 1 0 7
4 4 0 11 1 066 1 0 5
5 5 0 12 0 1ff 1 0 6
6 6 0 9 1 000 1 0 4
7 7 0 13 2 155 1 0 6
0 1 1 10 0 0aa 1 0 5
3 0 0 20 0 123 1 1 10
5 2 0 18 1 0cc 1 1 9
2 4 0 16 5 1a5 1 1 8
4 3 0 15 5 07e 1 1 7
1 0 0 12 1 0f0 0 0 0
6 2 1 12 0 11f 0 1 0
0 4 0 17 0 0d3 1 1 8

// ==== testbench/la_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module la_tb;

   typedef struct packed {
      logic [2:0]  trigger_source;
      logic [2:0]  capture_group;
      logic        manual;
      logic [15:0] depth;
      logic [15:0] downsample;
      logic [8:0]  pattern;
      logic        arm_flag;
      logic        random_ready;  // Else ready is held high
      logic [15:0] exp_words;
   } test_t;

   logic               observer_clk;
   logic               reset;
   la_pkg::la_config_t cfg;
   la_pkg::la_probes_t probes;
   logic               arm;
   logic               word_ready;
   logic               word_valid;
   la_pkg::la_word_t   word_data;
   logic               armed;
   logic               capturing;

   test_t       tests[$];
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int unsigned rand_value;

   la_top uut (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cfg          (cfg),
      .probes       (probes),
      .arm          (arm),
      .word_ready   (word_ready),
      .word_valid   (word_valid),
      .word_data    (word_data),
      .armed        (armed),
      .capturing    (capturing)
   );

   initial begin
      observer_clk = 1'b0;
      forever #10 observer_clk = ~observer_clk;
   end

   // Watchdog
   always @(posedge observer_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $fatal(1, "Timeout");
      end
   end

   task automatic next_cycle;
      @(posedge observer_clk);
      #2; // Drive and sample away from the edge
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Regression failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Word layout: channel k in bits 2k+1 and 2k
   function automatic logic [la_pkg::word_width-1:0] duplicate_channels(
      input logic [8:0] chan);
      logic [la_pkg::word_width-1:0] w;
      for (int k = 0; k < 9; k++) begin
         w[2*k+1] = chan[k];
         w[2*k]   = chan[k];
      end
      return w;
   endfunction

   function automatic logic [8:0] expected_channels(input la_pkg::la_probes_t p,
                                                   input logic [2:0] grp);
      case (grp)
         3'd0:    return p.glitch;
         3'd1:    return p.io;
         3'd2:    return p.userio;
         3'd3:    return p.debug;
         3'd4:    return p.trace;
         default: return 9'h155; // Alternating, channel 0 high
      endcase
   endfunction

   // Sets the probe bit that a trigger source code watches
   function automatic la_pkg::la_probes_t with_trigger(input la_pkg::la_probes_t p,
                                                       input logic [2:0] src,
                                                       input logic level);
      la_pkg::la_probes_t r;
      r = p;
      case (src)
         3'd0:    r.glitch[4] = level;
         3'd1:    r.glitch[5] = level;
         3'd2:    r.glitch[7] = level;
         3'd3:    r.io[4]     = level;
         3'd4:    r.glitch[8] = level;
         3'd5:    r.debug[0]  = level;
         default: r.debug[1]  = level;
      endcase
      return r;
   endfunction

   task automatic read_stimulus;
      int    fd;
      int    fields;
      string line;
      test_t t;
      int    src, grp, man, depth, ds, pat, armf, rdy, nw;
      fd = $fopen("testbench/la_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/la_stimulus.txt");
         $display("Regression failed");
         $fatal(1, "No stimulus");
      end
      while (!$feof(fd)) begin
         line   = "";
         fields = $fgets(line, fd);
         fields = $sscanf(line, "%d %d %d %d %d %h %d %d %d",
                          src, grp, man, depth, ds, pat, armf, rdy, nw);
         if (fields == 9) begin // Comment lines fail to parse
            t.trigger_source = src[2:0];
            t.capture_group  = grp[2:0];
            t.manual         = man[0];
            t.depth          = depth[15:0];
            t.downsample     = ds[15:0];
            t.pattern        = pat[8:0];
            t.arm_flag       = armf[0];
            t.random_ready   = rdy[0];
            t.exp_words      = nw[15:0];
            tests.push_back(t);
         end
      end
      $fclose(fd);
      assert (tests.size() > 0) else begin
         $display("The stimulus file holds no test lines");
         $display("Regression failed");
         $fatal(1, "Empty stimulus");
      end
      cycle_limit = 200;
      foreach (tests[i])
         cycle_limit += 4 * (tests[i].depth + 2) * (tests[i].downsample + 1);
   endtask

   task automatic run_test(input test_t t);
      la_pkg::la_probes_t            base;
      la_pkg::la_probes_t            fired;
      logic [la_pkg::word_width-1:0] exp_word;
      logic                          ready_next;
      int                            words;
      int                            wait_cycles;
      base.glitch = ~t.pattern; // Misrouting shows up as inverted data
      base.io     = ~t.pattern;
      base.userio = ~t.pattern;
      base.debug  = ~t.pattern;
      base.trace  = ~t.pattern;
      case (t.capture_group)
         3'd0: base.glitch = t.pattern;
         3'd1: base.io     = t.pattern;
         3'd2: base.userio = t.pattern;
         3'd3: base.debug  = t.pattern;
         3'd4: base.trace  = t.pattern;
         default: ;
      endcase
      base     = with_trigger(base, t.trigger_source, 1'b0);
      fired    = t.manual ? base : with_trigger(base, t.trigger_source, 1'b1);
      exp_word = duplicate_channels(expected_channels(fired, t.capture_group));

      cfg.trigger_source = t.trigger_source;
      cfg.capture_group  = t.capture_group;
      cfg.manual_capture = 1'b0;
      cfg.depth          = t.depth;
      cfg.downsample     = t.downsample;
      probes             = base;
      word_ready         = 1'b1;
      repeat (6) next_cycle; // Synchronizers settle low
      check_value("armed", armed, 1'b0);

      if (t.arm_flag) begin
         arm = 1'b1;
         while (!armed)
            next_cycle;
         arm = 1'b0;
      end
      else begin
         repeat (4) next_cycle;
         check_value("armed", armed, 1'b0);
      end

      if (t.manual)
         cfg.manual_capture = 1'b1;
      else
         probes = fired;

      words = 0;
      if (t.arm_flag) begin
         while (!capturing)
            next_cycle;
         check_value("armed", armed, 1'b0);
         while (capturing || word_valid) begin
            rand_value = $urandom;
            ready_next = t.random_ready ? rand_value[0] : 1'b1;
            word_ready = ready_next;
            if (word_valid && ready_next) begin
               words++; // Transfers on the coming edge
               check_value("word_data", word_data, exp_word);
            end
            next_cycle;
         end
      end

      // Nothing more may come out
      word_ready  = 1'b1;
      wait_cycles = (t.arm_flag ? 2 : t.depth + 2) * (t.downsample + 1) + 4;
      repeat (wait_cycles) begin
         next_cycle;
         check_value("word_valid", word_valid, 1'b0);
         check_value("capturing", capturing, 1'b0);
      end
      check_value("armed", armed, 1'b0);
      check_value("word count", words, t.exp_words);

      // Second trigger edge without arming again
      cfg.manual_capture = 1'b0;
      probes             = base;
      repeat (5) next_cycle;
      if (t.manual)
         cfg.manual_capture = 1'b1;
      else
         probes = fired;
      repeat (8) begin
         next_cycle;
         check_value("word_valid", word_valid, 1'b0);
         check_value("capturing", capturing, 1'b0);
         check_value("armed", armed, 1'b0);
      end
      cfg.manual_capture = 1'b0;
      probes             = base;
   endtask

   initial begin
      rand_value = $urandom(24);
      reset      = 1'b1;
      arm        = 1'b0;
      word_ready = 1'b1;
      cfg        = '0;
      probes     = '0;
      read_stimulus();
      repeat (8) next_cycle;
      reset = 1'b0;
      next_cycle;
      check_value("word_valid", word_valid, 1'b0);
      check_value("armed", armed, 1'b0);
      check_value("capturing", capturing, 1'b0);

      foreach (tests[i]) begin
         $display("Test %0d: source %0d group %0d depth %0d downsample %0d",
                  i, tests[i].trigger_source, tests[i].capture_group,
                  tests[i].depth, tests[i].downsample);
         run_test(tests[i]);
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
